//--- include/conv_macros.svh
/* build-time sizes of the streaming convolver
   included by the package and by the row delay line */
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

// side length of the square kernel
`define CONV_KERNEL 3

// largest image side the line buffers can hold
`define CONV_MAX_SIZE 16

// width of pixels and weights
`define CONV_PIX_BITS 8

// one full product plus four guard bits for the nine-term sum
`define CONV_ACC_BITS 20

`endif

//--- src/conv_pkg.sv
/* shared types and derived constants of the convolver
   imported by every RTL module */
`include "conv_macros.svh"

package conv_pkg;

  localparam int unsigned KERNEL = `CONV_KERNEL;
  localparam int unsigned TAPS = KERNEL * KERNEL;  // one mac per weight
  localparam int unsigned TAP_BITS = $clog2(`CONV_MAX_SIZE - `CONV_KERNEL + 1);

  typedef logic signed [`CONV_PIX_BITS-1:0] pixel_t;
  typedef logic signed [`CONV_PIX_BITS-1:0] weight_t;
  typedef logic signed [`CONV_ACC_BITS-1:0] acc_t;

  // image side, 3 up to the max size
  typedef logic [$clog2(`CONV_MAX_SIZE + 1)-1:0] size_t;

  // stride, 1 to 3
  typedef logic [1:0] stride_t;

endpackage

//--- src/pixel_ingress.sv
/* four-phase pixel receiver, one advance strobe per accepted pixel
   ack is held back while the result buffer lacks room */
module pixel_ingress (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             pix_req_i,
  input  conv_pkg::pixel_t pix_data_i,
  input  logic             room_i,
  output logic             pix_ack_o,
  output logic             advance_o,
  output conv_pkg::pixel_t pixel_o
);
  import conv_pkg::*;

  typedef enum logic {S_IDLE, S_ACK} state_e;

  state_e state_q;
  logic   advance_q;
  logic   accept;
  pixel_t pixel_q;

  // new request seen while ack is low and the egress can take a result
  assign accept = (state_q == S_IDLE) && pix_req_i && room_i;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q   <= S_IDLE;
      advance_q <= 1'b0;
    end else begin
      advance_q <= accept;  // single-cycle strobe
      case (state_q)
        S_IDLE: if (accept) state_q <= S_ACK;
        S_ACK:  if (!pix_req_i) state_q <= S_IDLE;  // source released req
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      pixel_q <= pix_data_i;  // data is stable while req is high
    end
  end

  assign pix_ack_o = (state_q == S_ACK);
  assign advance_o = advance_q;
  assign pixel_o   = pixel_q;

endmodule

//--- src/line_delay.sv
/* row delay line for partial sums, moves only on shift
   the output tap follows the run-time image width */
`include "conv_macros.svh"

module line_delay (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         shift_i,
  input  conv_pkg::acc_t               data_i,
  input  logic [conv_pkg::TAP_BITS-1:0] tap_i,
  output conv_pkg::acc_t               data_o
);
  import conv_pkg::*;

  localparam int unsigned LEN = `CONV_MAX_SIZE - `CONV_KERNEL;

  acc_t stage_q [LEN];

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int i = 0; i < LEN; i++) begin
        stage_q[i] <= '0;
      end
    end else if (shift_i) begin
      stage_q[0] <= data_i;
      for (int i = 1; i < LEN; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  // tap 0 is the smallest image, where the row end register meets the next row directly
  assign data_o = (tap_i == '0) ? data_i : stage_q[tap_i - 1'b1];

endmodule

//--- src/conv_window_ctrl.sv
/* column and row tracking of the pixel being accepted
   flags the pixels that complete a kept window and the last one of the frame */
module conv_window_ctrl (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              advance_i,
  input  conv_pkg::size_t   img_size_i,
  input  conv_pkg::stride_t stride_i,
  output logic              window_ok_o,
  output logic              last_window_o
);
  import conv_pkg::*;

  localparam size_t FIRST = size_t'(KERNEL - 1);  // first position with a full window

  size_t   col_q;
  size_t   row_q;
  stride_t col_ph_q;
  stride_t row_ph_q;
  logic    col_end;
  logic    row_end;
  logic    col_final;
  logic    row_final;

  // stride phase, restarts at the first full window position
  function automatic stride_t next_phase(size_t pos, stride_t ph);
    stride_t nxt;
    if (pos < FIRST || ph == stride_i - 2'd1) nxt = '0;
    else nxt = ph + 2'd1;
    return nxt;
  endfunction

  assign col_end = (col_q == img_size_i - size_t'(1));
  assign row_end = (row_q == img_size_i - size_t'(1));

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      col_q    <= '0;
      row_q    <= '0;
      col_ph_q <= '0;
      row_ph_q <= '0;
    end else if (advance_i) begin
      if (col_end) begin
        col_q    <= '0;
        col_ph_q <= '0;
        if (row_end) begin  // frame wraps
          row_q    <= '0;
          row_ph_q <= '0;
        end else begin
          row_q    <= row_q + size_t'(1);
          row_ph_q <= next_phase(row_q, row_ph_q);
        end
      end else begin
        col_q    <= col_q + size_t'(1);
        col_ph_q <= next_phase(col_q, col_ph_q);
      end
    end
  end

  assign window_ok_o = (col_q >= FIRST) && (row_q >= FIRST) &&
                       (col_ph_q == '0) && (row_ph_q == '0);

  // no further kept window fits to the right or below
  assign col_final = ({1'b0, col_q} + 6'(stride_i)) >= {1'b0, img_size_i};
  assign row_final = ({1'b0, row_q} + 6'(stride_i)) >= {1'b0, img_size_i};

  assign last_window_o = window_ok_o && col_final && row_final;

endmodule

//--- src/conv_engine.sv
/* 3x3 multiply-accumulate chain over the pixel stream
   row sums pass through delay lines into the next kernel row, one cycle latency */
module conv_engine (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              advance_i,
  input  conv_pkg::pixel_t  pixel_i,
  input  conv_pkg::weight_t weights_i [conv_pkg::TAPS],
  input  conv_pkg::size_t   img_size_i,
  input  conv_pkg::stride_t stride_i,
  output conv_pkg::acc_t    result_o,
  output logic              result_valid_o,
  output logic              result_last_o
);
  import conv_pkg::*;

  acc_t                acc_q  [TAPS];
  acc_t                addend [TAPS];
  acc_t                row_in [1:KERNEL-1];  // delayed sums of the row above
  logic [TAP_BITS-1:0] tap;
  logic                window_ok;
  logic                last_window;
  logic                valid_q;
  logic                last_q;

  assign tap = TAP_BITS'(img_size_i - size_t'(KERNEL));

  conv_window_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .advance_i    (advance_i),
    .img_size_i   (img_size_i),
    .stride_i     (stride_i),
    .window_ok_o  (window_ok),
    .last_window_o(last_window)
  );

  for (genvar r = 1; r < KERNEL; r++) begin : g_row
    line_delay u_line (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .shift_i(advance_i),
      .data_i (acc_q[r*KERNEL-1]),  // end of the row above
      .tap_i  (tap),
      .data_o (row_in[r])
    );
  end

  always_comb begin
    for (int i = 0; i < TAPS; i++) begin
      if (i == 0) addend[i] = '0;
      else if (i % KERNEL == 0) addend[i] = row_in[i/KERNEL];  // first tap of a lower row
      else addend[i] = acc_q[i-1];
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance_i) begin
      for (int i = 0; i < TAPS; i++) begin
        acc_q[i] <= acc_t'(pixel_i) * acc_t'(weights_i[i]) + addend[i];
      end
    end
  end

  // flags aligned with the final tap
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      valid_q <= advance_i && window_ok;
      last_q  <= advance_i && last_window;
    end
  end

  assign result_o       = acc_q[TAPS-1];
  assign result_valid_o = valid_q;
  assign result_last_o  = last_q;

endmodule

//--- src/result_egress.sv
/* four-entry result FIFO drained by a four-phase sender
   room tells the ingress that a result in flight still fits */
module result_egress (
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic           wr_i,
  input  conv_pkg::acc_t wr_data_i,
  input  logic           wr_last_i,
  output logic           room_o,
  output logic           res_req_o,
  output conv_pkg::acc_t res_data_o,
  output logic           res_last_o,
  input  logic           res_ack_i
);
  import conv_pkg::*;

  localparam int unsigned DEPTH = 4;
  localparam int unsigned PTR_BITS = $clog2(DEPTH);

  typedef enum logic [1:0] {S_IDLE, S_WAIT_HI, S_WAIT_LO} state_e;

  acc_t                data_mem [DEPTH];
  logic [DEPTH-1:0]    last_mem;
  logic [PTR_BITS-1:0] wr_ptr_q;
  logic [PTR_BITS-1:0] rd_ptr_q;
  logic [PTR_BITS:0]   count_q;
  state_e              state_q;
  acc_t                data_q;
  logic                last_q;
  logic                pop;

  assign pop    = (state_q == S_IDLE) && (count_q != '0);
  assign room_o = count_q <= (PTR_BITS + 1)'(DEPTH - 2);  // two entries free

  always_ff @(posedge clk_i) begin
    if (wr_i) begin
      data_mem[wr_ptr_q] <= wr_data_i;
      last_mem[wr_ptr_q] <= wr_last_i;
    end
    if (pop) data_q <= data_mem[rd_ptr_q];  // held for the whole transfer
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      state_q  <= S_IDLE;
      last_q   <= 1'b0;
    end else begin
      if (wr_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
        last_q   <= last_mem[rd_ptr_q];
      end
      count_q <= count_q + (PTR_BITS + 1)'(wr_i) - (PTR_BITS + 1)'(pop);
      case (state_q)
        S_IDLE:    if (pop) state_q <= S_WAIT_HI;
        S_WAIT_HI: if (res_ack_i) state_q <= S_WAIT_LO;  // req drops here
        S_WAIT_LO: if (!res_ack_i) state_q <= S_IDLE;
        default:   state_q <= S_IDLE;
      endcase
    end
  end

  assign res_req_o  = (state_q == S_WAIT_HI);
  assign res_data_o = data_q;
  assign res_last_o = last_q;

endmodule

//--- src/conv_top.sv
/* streaming 2-D convolver, pixels in and results out over four-phase ports
   configuration must stay stable for the duration of a frame */
module conv_top (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              pix_req_i,
  input  conv_pkg::pixel_t  pix_data_i,
  output logic              pix_ack_o,
  input  conv_pkg::size_t   img_size_i,
  input  conv_pkg::stride_t stride_i,
  input  conv_pkg::weight_t weights_i [conv_pkg::TAPS],
  output logic              res_req_o,
  output conv_pkg::acc_t    res_data_o,
  output logic              res_last_o,
  input  logic              res_ack_i
);
  import conv_pkg::*;

  logic   advance;
  pixel_t pixel;
  logic   room;
  logic   result_valid;
  logic   result_last;
  acc_t   result;

  pixel_ingress u_ingress (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .pix_req_i (pix_req_i),
    .pix_data_i(pix_data_i),
    .room_i    (room),
    .pix_ack_o (pix_ack_o),
    .advance_o (advance),
    .pixel_o   (pixel)
  );

  conv_engine u_engine (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .advance_i     (advance),
    .pixel_i       (pixel),
    .weights_i     (weights_i),
    .img_size_i    (img_size_i),
    .stride_i      (stride_i),
    .result_o      (result),
    .result_valid_o(result_valid),
    .result_last_o (result_last)
  );

  result_egress u_egress (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .wr_i      (result_valid),
    .wr_data_i (result),
    .wr_last_i (result_last),
    .room_o    (room),
    .res_req_o (res_req_o),
    .res_data_o(res_data_o),
    .res_last_o(res_last_o),
    .res_ack_i (res_ack_i)
  );

endmodule

//--- dv/conv_checker.sv
/* four-phase protocol assertions on the pixel and result ports
   bound into the convolver top level by the testbench */
module conv_checker (
  input logic              clk_i,
  input logic              rst_i,
  input logic              pix_req_i,
  input conv_pkg::pixel_t  pix_data_i,
  input logic              pix_ack_o,
  input logic              res_req_o,
  input conv_pkg::acc_t    res_data_o,
  input logic              res_last_o,
  input logic              res_ack_i
);
  timeunit 1ns;
  timeprecision 1ps;

  pix_data_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    pix_req_i && !pix_ack_o |=> $stable(pix_data_i))
    else $error("pixel data changed while waiting for ack");

  pix_req_held: assert property (@(posedge clk_i) disable iff (rst_i)
    pix_req_i && !pix_ack_o |=> pix_req_i)
    else $error("pixel req dropped before ack");

  pix_ack_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(pix_ack_o) |-> pix_req_i)
    else $error("pixel ack rose without req");

  res_data_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    res_req_o && !res_ack_i |=> $stable(res_data_o) && $stable(res_last_o))
    else $error("result data changed while waiting for ack");

  res_req_held: assert property (@(posedge clk_i) disable iff (rst_i)
    res_req_o && !res_ack_i |=> res_req_o)
    else $error("result req dropped before ack");

  res_ack_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(res_ack_i) |-> res_req_o)
    else $error("result ack rose without req");

endmodule

//--- dv/conv_tb.sv
/* testbench for the streaming convolver, random frames through both four-phase ports
   results are checked against a window-sum model built from the pixels sent */
`include "conv_macros.svh"

module conv_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import conv_pkg::*;

  localparam int NUM_FRAMES = 8;
  localparam int MAX_PIX = `CONV_MAX_SIZE * `CONV_MAX_SIZE;

  logic    clk_i;
  logic    rst_i;
  logic    pix_req;
  pixel_t  pix_data;
  logic    pix_ack;
  size_t   img_size;
  stride_t stride;
  weight_t weights [TAPS];
  logic    res_req;
  acc_t    res_data;
  logic    res_last;
  logic    res_ack;

  int      frame_n [NUM_FRAMES];
  pixel_t  frame_pix [MAX_PIX];
  weight_t frame_w [TAPS];
  int      exp_data_q [$];
  int      exp_last_q [$];
  int      total_exp = 0;
  int      results_seen = 0;
  int      stalls = 0;
  int      cycles = 0;
  int      limit;
  bit      slow_ack;

  conv_top dut_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .pix_req_i (pix_req),
    .pix_data_i(pix_data),
    .pix_ack_o (pix_ack),
    .img_size_i(img_size),
    .stride_i  (stride),
    .weights_i (weights),
    .res_req_o (res_req),
    .res_data_o(res_data),
    .res_last_o(res_last),
    .res_ack_i (res_ack)
  );

  bind conv_top conv_checker u_checker (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;  // 8 ns period
  end

  task automatic check(input int got, input int exp, input string msg);
    if (got !== exp) begin
      $display("CHECK FAILED at %0d ns: %s, got %0d expected %0d", $time, msg, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles > limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("TESTS FAILED");
      $fatal(1, "cycle limit reached");
    end
  end

  // kind 3 is all full-scale negative, kind 4 alternates signs
  task automatic fill_frame(input int kind, input int n);
    for (int k = 0; k < n * n; k++) begin
      case (kind)
        3:       frame_pix[k] = pixel_t'(-128);
        4:       frame_pix[k] = ((k + k / n) % 2 != 0) ? pixel_t'(127) : pixel_t'(-128);
        default: frame_pix[k] = pixel_t'($urandom);
      endcase
    end
    for (int i = 0; i < TAPS; i++) begin
      case (kind)
        3:       frame_w[i] = weight_t'(-128);
        4:       frame_w[i] = (i % 2 != 0) ? weight_t'(-128) : weight_t'(127);
        default: frame_w[i] = weight_t'($urandom);
      endcase
    end
  endtask

  // expected results in raster order, windows anchored on stride multiples
  task automatic model_frame(input int n, input int s);
    int last_pos;
    int sum;
    last_pos = 2 + ((n - 3) / s) * s;
    for (int r = 2; r < n; r += s) begin
      for (int c = 2; c < n; c += s) begin
        sum = 0;
        for (int i = 0; i < 3; i++) begin
          for (int j = 0; j < 3; j++) begin
            sum += int'(frame_w[i * 3 + j]) * int'(frame_pix[(r - 2 + i) * n + c - 2 + j]);
          end
        end
        exp_data_q.push_back(sum);
        exp_last_q.push_back((r == last_pos && c == last_pos) ? 1 : 0);
        total_exp++;
      end
    end
  endtask

  task automatic send_pixel(input pixel_t p);
    int waits;
    @(posedge clk_i);
    pix_req  <= 1'b1;
    pix_data <= p;
    waits = 0;
    do begin
      @(negedge clk_i);
      waits++;
    end while (!pix_ack);
    if (waits > 4) stalls++;  // ack held back by the egress
    @(posedge clk_i);
    pix_req <= 1'b0;
    do @(negedge clk_i); while (pix_ack);
    repeat ($urandom % 4) @(posedge clk_i);
  endtask

  task automatic send_frame(input int n, input int s);
    @(posedge clk_i);
    img_size <= size_t'(n);
    stride   <= stride_t'(s);
    for (int i = 0; i < TAPS; i++) begin
      weights[i] <= frame_w[i];
    end
    for (int k = 0; k < n * n; k++) begin
      send_pixel(frame_pix[k]);
    end
  endtask

  // result sink with random ack delays
  initial begin
    int delay;
    forever begin
      @(negedge clk_i);
      if (res_req) begin
        check((exp_data_q.size() != 0) ? 1 : 0, 1, "result arrived with none expected");
        check(int'(res_data), exp_data_q.pop_front(),
              $sformatf("value of result %0d", results_seen));
        check(int'(res_last), exp_last_q.pop_front(),
              $sformatf("last flag of result %0d", results_seen));
        results_seen++;
        delay = slow_ack ? $urandom % 24 : $urandom % 3;
        repeat (delay) @(posedge clk_i);
        @(posedge clk_i);
        res_ack <= 1'b1;
        do @(negedge clk_i); while (res_req);
        @(posedge clk_i);
        res_ack <= 1'b0;
      end
    end
  end

  initial begin
    int s;
    void'($urandom(8415));
    rst_i    = 1'b1;
    pix_req  = 1'b0;
    pix_data = '0;
    res_ack  = 1'b0;
    img_size = size_t'(3);
    stride   = stride_t'(1);
    slow_ack = 1'b0;
    for (int i = 0; i < TAPS; i++) begin
      weights[i] = '0;
    end
    limit = 1000;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      if (f == 3 || f == 5) frame_n[f] = 16;  // full size, extreme and slow frames
      else if (f == 6) frame_n[f] = 3;
      else frame_n[f] = 3 + $urandom % 14;
      limit += frame_n[f] * frame_n[f] * 40;
    end
    repeat (8) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    check(int'(res_req), 0, "res_req_o after reset");
    check(int'(pix_ack), 0, "pix_ack_o after reset");
    for (int f = 0; f < NUM_FRAMES; f++) begin
      if (f == 1) s = 2;
      else if (f == 2) s = 3;
      else if (f == 4 || f == 7) s = 1 + $urandom % 3;
      else s = 1;
      fill_frame(f, frame_n[f]);
      model_frame(frame_n[f], s);
      slow_ack = (f == 5);  // long result acks
      send_frame(frame_n[f], s);
    end
    while (results_seen < total_exp) @(negedge clk_i);
    repeat (50) @(negedge clk_i);  // catch stray extra results
    check((stalls > 0) ? 1 : 0, 1, "pixel stalls under result back-pressure");
    if (results_seen == total_exp && exp_data_q.size() == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("the number of results does not match the model");
      $display("TESTS FAILED");
      $fatal(1, "result count mismatch");
    end
  end

endmodule

//--- sim.f
+incdir+include
src/conv_pkg.sv
src/pixel_ingress.sv
src/line_delay.sv
src/conv_window_ctrl.sv
src/conv_engine.sv
src/result_egress.sv
src/conv_top.sv
dv/conv_checker.sv
dv/conv_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := conv_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir
LOG       := sim.log
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
